// ==== project.f ====
verilog/bias_pkg.sv
verilog/pixel_receiver.sv
verilog/stream_fifo.sv
verilog/bias_add.sv
verilog/result_sender.sv
verilog/bias_stage_top.sv
verif/bias_stage_asserts.sv
verif/bias_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the bias stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f project.f \
  --top-module bias_stage_tb \
  -Mdir obj_dir

# A stopped simulation still reaches the search below
sim_output=$(./obj_dir/Vbias_stage_tb 2>&1) || true
echo "$sim_output"

if grep -qx "Done: no errors" <<< "$sim_output"; then
  exit 0
else
  exit 1
fi

// ==== verif/bias_stage_asserts.sv ====
`timescale 1ns/100ps

module bias_stage_asserts (
  input logic                         clk,
  input logic                         reset,
  input logic                         in_req,
  input logic [bias_pkg::PIXEL_W-1:0] in_pixel,
  input logic [bias_pkg::CHAN_W-1:0]  in_channel,
  input logic                         out_req,
  input logic                         out_ack,
  input logic [bias_pkg::ACC_W-1:0]   out_data,
  input logic                         pixel_push,
  input logic [bias_pkg::LEVEL_W-1:0] pixel_level,
  input logic                         result_push,
  input logic [bias_pkg::LEVEL_W-1:0] result_level
);

  //////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////

  in_data_stable: assert property (@(posedge clk) disable iff (reset)
    in_req && $past(in_req) |-> $stable(in_pixel) && $stable(in_channel))
    else $error("Input data changed while in_req was high");

  out_data_stable: assert property (@(posedge clk) disable iff (reset)
    out_req && $past(out_req) |-> $stable(out_data))
    else $error("out_data changed while out_req was high");

  // Req held until the sink answers
  out_req_held: assert property (@(posedge clk) disable iff (reset)
    out_req && !out_ack |=> out_req)
    else $error("out_req fell before out_ack rose");

  //////////////////////////////////////////////////
  // FIFO levels
  //////////////////////////////////////////////////

  // A push at full would be dropped, the level would pass the depth
  pixel_level_ok: assert property (@(posedge clk) disable iff (reset)
    pixel_push |-> int'(pixel_level) < bias_pkg::IN_FIFO_DEPTH)
    else $error("Pixel FIFO pushed while at its depth");

  result_level_ok: assert property (@(posedge clk) disable iff (reset)
    result_push |-> int'(result_level) < bias_pkg::OUT_FIFO_DEPTH)  // Credit check keeps this
    else $error("Result FIFO pushed while at its depth");

endmodule

bind bias_stage_top bias_stage_asserts bias_stage_asserts_i (
  .clk (clk), .reset (reset),
  .in_req (in_req), .in_pixel (in_pixel), .in_channel (in_channel),
  .out_req (out_req), .out_ack (out_ack), .out_data (out_data),
  .pixel_push (pixel_push), .pixel_level (pixel_level),
  .result_push (result_push), .result_level (result_level)
);

// ==== verif/bias_stage_tb.sv ====
`timescale 1ns/100ps

module bias_stage_tb;

  // One stimulus row
  typedef struct {
    logic [bias_pkg::PIXEL_W-1:0] pixel;
    logic [bias_pkg::CHAN_W-1:0]  channel;
    bit                           load;   // Write bias before the pixel
    logic [bias_pkg::BIAS_W-1:0]  bias;
    int                           delay;  // Ack delay in cycles, -1 for random
  } row_t;

  logic                          clk = 1'b0;
  logic                          reset;
  logic                          in_req;
  logic [bias_pkg::PIXEL_W-1:0]  in_pixel;
  logic [bias_pkg::CHAN_W-1:0]   in_channel;
  logic                          in_ack;
  logic                          bias_wr_en;
  logic [bias_pkg::CHAN_W-1:0]   bias_wr_channel;
  logic [bias_pkg::BIAS_W-1:0]   bias_wr_data;
  logic                          out_ack;
  logic                          out_req;
  logic [bias_pkg::ACC_W-1:0]    out_data;

  row_t                          rows[$];
  bias_pkg::acc_t                expect_q[$];  // Sums in send order
  logic [bias_pkg::BIAS_W-1:0]   bias_model [bias_pkg::NUM_CHANNELS];
  int unsigned                   lcg_state = 85453;
  int                            errors = 0;
  int                            checks = 0;
  bit                            table_ready = 1'b0;

  always #4 clk = ~clk;  // 8 ns period

  bias_stage_top bias_stage_top_i (
    .clk, .reset,
    .in_req, .in_pixel, .in_channel, .in_ack,
    .bias_wr_en, .bias_wr_channel, .bias_wr_data,
    .out_ack, .out_req, .out_data
  );

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic step();
    @(posedge clk);
    #1;  // Drive and sample just after the edge
  endtask

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Pixel times 2^16 plus the 25-bit bias times 2^(16-P), P clamped at 16
  function automatic bias_pkg::acc_t expected_sum(input logic [31:0] pixel,
                                                  input logic [31:0] word);
    longint pix;
    longint bias;
    longint total;
    int     point;
    point = int'(word[30:24]);
    if (point > 16) point = 16;
    pix   = longint'($signed(pixel));
    bias  = longint'($signed({word[31], word[23:0]}));
    total = pix * 65536 + bias * (longint'(1) << (16 - point));
    return total[47:0];  // Modulo 2^48
  endfunction

  task automatic check_value(input string name, input logic [47:0] got,
                             input logic [47:0] want, output bit ok);
    checks++;
    ok = (got === want);
    if (!ok) begin
      errors++;
      $display("Mismatch on %s: got 0x%012h, expected 0x%012h", name, got, want);
    end
  endtask

  task automatic add_row(input logic [31:0] pixel, input logic [3:0] channel,
                         input bit load, input logic [31:0] bias, input int delay);
    row_t r;
    r.pixel   = pixel;
    r.channel = channel;
    r.load    = load;
    r.bias    = bias;
    r.delay   = delay;
    rows.push_back(r);
  endtask

  task automatic write_bias(input logic [3:0] channel, input logic [31:0] word);
    bias_wr_en      = 1'b1;
    bias_wr_channel = channel;
    bias_wr_data    = word;
    step();
    bias_wr_en      = 1'b0;
    bias_model[channel] = word;  // Table holds it from this edge on
  endtask

  //////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////

  task automatic fill_table();
    add_row(32'd100, 4'd0, 1'b1, {1'b0, 7'd16, 24'h000123}, 0);  // P = 16, plain add
    for (int p = 0; p <= 16; p++) begin
      add_row(32'(p * 3 + 1), 4'd1, 1'b1, {1'b0, 7'(p), 24'h0000A5}, 1);  // Every P
    end
    add_row(32'hFFFF_FF00, 4'd2, 1'b1, {1'b1, 7'd12, 24'hFFFFF0}, 2);  // Both negative
    add_row(32'hFFFF_FFFF, 4'd2, 1'b1, {1'b0, 7'd16, 24'h010000}, 0);  // Wraps to zero
    add_row(32'h7FFF_FFFF, 4'd2, 1'b1, {1'b0, 7'd0, 24'h7FFFFF}, 3);   // Largest positive
    add_row(32'h8000_0000, 4'd2, 1'b1, {1'b1, 7'd0, 24'h000000}, 1);   // Wraps below -2^47
    add_row(32'd7, 4'd3, 1'b1, {1'b0, 7'd8, 24'h000200}, 12);
    add_row(32'd7, 4'd4, 1'b0, 32'h0, 0);                              // Other channel
    add_row(32'd7, 4'd3, 1'b1, {1'b1, 7'd8, 24'hFFFE00}, 12);          // Rewrite ch 3
    add_row(32'd7, 4'd4, 1'b0, 32'h0, 0);
    add_row(32'd7, 4'd3, 1'b0, 32'h0, 0);
    add_row(32'd55, 4'd5, 1'b1, {1'b0, 7'd17, 24'h000321}, 0);  // P above 16
    add_row(32'd55, 4'd5, 1'b1, {1'b0, 7'h7F, 24'h000321}, 0);
    add_row(32'd55, 4'd5, 1'b1, {1'b0, 7'd16, 24'h000321}, 0);
    for (int i = 0; i < 8; i++) begin
      add_row(lcg_next(), 4'(i + 6), 1'b0, 32'h0, -1);  // Slow random ack
    end
  endtask

  //////////////////////////////////////////////////
  // Source and sink
  //////////////////////////////////////////////////

  task automatic send_pixel(input logic [31:0] pixel, input logic [3:0] channel);
    in_pixel   = pixel;
    in_channel = channel;
    in_req     = 1'b1;
    do step(); while (!in_ack);
    in_req = 1'b0;
    do step(); while (in_ack);  // Four-phase return to zero
  endtask

  task automatic send_rows();
    foreach (rows[i]) begin
      if (rows[i].load) write_bias(rows[i].channel, rows[i].bias);
      expect_q.push_back(expected_sum(rows[i].pixel, bias_model[rows[i].channel]));
      send_pixel(rows[i].pixel, rows[i].channel);
    end
  endtask

  task automatic receive_rows();
    int             delay;
    bias_pkg::acc_t want;
    bit             ok;
    foreach (rows[k]) begin
      do step(); while (!out_req);
      delay = (rows[k].delay < 0) ? int'((lcg_next() >> 16) % 16) : rows[k].delay;
      repeat (delay) step();
      if (expect_q.size() == 0) begin
        $display("A result arrived with no pixel sent for it");
        errors++;
        want = '0;
      end else begin
        want = expect_q.pop_front();
      end
      check_value("out_data", out_data, want, ok);
      $display("Row %0d ch %0d pixel 0x%08h result 0x%012h: %s", k, rows[k].channel,
               rows[k].pixel, out_data, ok ? "ok" : "FAILED");
      out_ack = 1'b1;
      do step(); while (out_req);
      out_ack = 1'b0;
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    reset           = 1'b1;
    in_req          = 1'b0;
    in_pixel        = '0;
    in_channel      = '0;
    bias_wr_en      = 1'b0;
    bias_wr_channel = '0;
    bias_wr_data    = '0;
    out_ack         = 1'b0;
    repeat (8) step();
    reset = 1'b0;
    for (int c = 0; c < bias_pkg::NUM_CHANNELS; c++) begin
      write_bias(4'(c), {1'b0, 7'(8 + c % 9), 24'(c * 4951)});  // Mixed P per channel
    end
    fill_table();
    table_ready = 1'b1;
    fork
      send_rows();
      receive_rows();
    join
    repeat (10) step();
    if (out_req) begin
      $display("An extra result appeared after the last row");
      errors++;
    end
    $display("Rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    int max_delay;
    int d;
    wait (table_ready);
    max_delay = 0;
    foreach (rows[i]) begin
      d = (rows[i].delay < 0) ? 15 : rows[i].delay;  // Random delays top out at 15
      if (d > max_delay) max_delay = d;
    end
    repeat (rows.size() * (max_delay + 20)) @(posedge clk);
    $display("Timeout: the rows did not all complete within the cycle budget");
    $display("Done: errors found");
    $finish;
  end

endmodule

// ==== verilog/bias_add.sv ====
`timescale 1ns/100ps

module bias_add (
  input  logic                         clk,
  input  logic                         reset,
  // Pixel FIFO read side
  input  logic                         src_empty,
  input  bias_pkg::pixel_entry_t       src_data,
  output logic                         src_pop,
  // Result FIFO write side
  input  logic [bias_pkg::LEVEL_W-1:0] dst_level,
  output logic                         dst_push,
  output bias_pkg::acc_t               dst_data
);

  // Pipeline valid bits, one per stage
  logic s1_valid;
  logic s2_valid;

  // Stage payloads
  bias_pkg::acc_t s1_pixel;  // Pixel times 2^16
  bias_pkg::acc_t s1_bias;   // Bias on the 16-bit fraction grid
  bias_pkg::acc_t s2_sum;

  logic [bias_pkg::LEVEL_W:0] committed;  // Held plus in flight
  logic                       issue;

  bias_pkg::acc_t pixel_aligned;
  bias_pkg::acc_t bias_aligned;

  //////////////////////////////////////////////////
  // Credit check
  //////////////////////////////////////////////////

  // No stall in the pipe, so every issued item needs a slot up front.
  // A pop on the result FIFO only frees room, so the level is safe.
  assign committed = {1'b0, dst_level}
                   + {{bias_pkg::LEVEL_W{1'b0}}, s1_valid}
                   + {{bias_pkg::LEVEL_W{1'b0}}, s2_valid};

  assign issue   = !src_empty && (int'(committed) < bias_pkg::OUT_FIFO_DEPTH);
  assign src_pop = issue;

  //////////////////////////////////////////////////
  // Alignment
  //////////////////////////////////////////////////

  always_comb begin
    logic                          sign;
    logic [bias_pkg::POINT_W-1:0]  point;
    logic [bias_pkg::SHIFT_W-1:0]  pos;
    logic [bias_pkg::SHIFT_W-1:0]  shift;
    logic [bias_pkg::VALUE_W-1:0]  value;
    bias_pkg::acc_t                bias_ext;

    sign  = src_data.bias[bias_pkg::BIAS_SIGN_BIT];
    point = src_data.bias[bias_pkg::POINT_LSB +: bias_pkg::POINT_W];
    value = src_data.bias[bias_pkg::VALUE_W-1:0];

    // P above 16 clamps to 16, i.e. no shift
    if (int'(point) > bias_pkg::FRAC_BITS) begin
      pos = bias_pkg::SHIFT_W'(bias_pkg::FRAC_BITS);
    end else begin
      pos = point[bias_pkg::SHIFT_W-1:0];
    end
    shift = bias_pkg::SHIFT_W'(bias_pkg::FRAC_BITS) - pos;  // 16 - P

    // Sign plus 24 value bits, extended to 48
    bias_ext = {{(bias_pkg::ACC_W - bias_pkg::VALUE_W - 1){sign}}, sign, value};

    bias_aligned  = bias_ext << shift;
    pixel_aligned = {src_data.pixel, {bias_pkg::FRAC_BITS{1'b0}}};  // Integer part up top
  end

  //////////////////////////////////////////////////
  // Pipeline
  //////////////////////////////////////////////////

  // Valid bits, cleared on reset
  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid <= issue;
      s2_valid <= s1_valid;
    end
  end

  // Stage 1 captures the aligned operands at issue
  always_ff @(posedge clk) begin
    if (issue) begin
      s1_pixel <= pixel_aligned;
      s1_bias  <= bias_aligned;
    end
  end

  // Stage 2, plain add modulo 2^48
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      s2_sum <= s1_pixel + s1_bias;
    end
  end

  assign dst_push = s2_valid;  // Two cycles after issue
  assign dst_data = s2_sum;

endmodule

// ==== verilog/bias_pkg.sv ====
package bias_pkg;

  //////////////////////////////////////////////////
  // Datapath widths
  //////////////////////////////////////////////////

  localparam int PIXEL_W   = 32;  // Normalized pixel result, signed
  localparam int BIAS_W    = 32;  // Packed bias word
  localparam int ACC_W     = 48;  // Aligned sum
  localparam int FRAC_BITS = 16;  // Fraction bits of the sum, also the largest point

  // Bias word layout
  //   [31]    sign
  //   [30:24] point position P
  //   [23:0]  low value bits
  localparam int BIAS_SIGN_BIT = 31;
  localparam int POINT_LSB     = 24;
  localparam int POINT_W       = 7;
  localparam int VALUE_W       = 24;

  // Shift amount 0..16 after the clamp
  localparam int SHIFT_W = 5;

  //////////////////////////////////////////////////
  // Channels and buffering
  //////////////////////////////////////////////////

  localparam int CHAN_W       = 4;
  localparam int NUM_CHANNELS = 16;  // One bias word each

  localparam int IN_FIFO_DEPTH  = 4;  // Pixel FIFO
  localparam int OUT_FIFO_DEPTH = 4;  // Result FIFO

  // Fill level 0..DEPTH, both FIFOs
  localparam int LEVEL_W = 3;

  //////////////////////////////////////////////////
  // Payload types
  //////////////////////////////////////////////////

  // Pixel with its bias word already looked up
  typedef struct packed {
    logic signed [PIXEL_W-1:0] pixel;  // Integer result from normalize
    logic [BIAS_W-1:0]         bias;   // Raw table word, fields split in bias_add
  } pixel_entry_t;

  // Result word, 32 integer bits over 16 fraction bits
  typedef logic [ACC_W-1:0] acc_t;

endpackage

// ==== verilog/bias_stage_top.sv ====
`timescale 1ns/100ps

module bias_stage_top (
  input  logic                        clk,
  input  logic                        reset,
  // Pixel input link
  input  logic                        in_req,
  input  logic [bias_pkg::PIXEL_W-1:0] in_pixel,
  input  logic [bias_pkg::CHAN_W-1:0]  in_channel,
  output logic                        in_ack,
  // Bias table load
  input  logic                        bias_wr_en,
  input  logic [bias_pkg::CHAN_W-1:0]  bias_wr_channel,
  input  logic [bias_pkg::BIAS_W-1:0]  bias_wr_data,
  // Result output link
  input  logic                        out_ack,
  output logic                        out_req,
  output logic [bias_pkg::ACC_W-1:0]   out_data
);

  //////////////////////////////////////////////////
  // Pixel path
  //////////////////////////////////////////////////

  logic                         pixel_push;
  bias_pkg::pixel_entry_t       pixel_push_data;
  logic                         pixel_full;
  logic                         pixel_pop;
  bias_pkg::pixel_entry_t       pixel_pop_data;
  logic                         pixel_empty;
  logic [bias_pkg::LEVEL_W-1:0] pixel_level;  // Watched by the bound checks

  // Result path
  logic                         result_push;
  bias_pkg::acc_t               result_push_data;
  logic                         result_pop;
  bias_pkg::acc_t               result_pop_data;
  logic                         result_empty;
  logic [bias_pkg::LEVEL_W-1:0] result_level;  // Credit for bias_add

  pixel_receiver pixel_receiver_i (
    .clk, .reset,
    .in_req, .in_pixel, .in_channel, .in_ack,
    .bias_wr_en, .bias_wr_channel, .bias_wr_data,
    .fifo_full      (pixel_full),
    .fifo_push      (pixel_push),
    .fifo_push_data (pixel_push_data)
  );

  stream_fifo #(
    .payload_t (bias_pkg::pixel_entry_t),
    .DEPTH     (bias_pkg::IN_FIFO_DEPTH)
  ) pixel_fifo (
    .clk, .reset,
    .push (pixel_push), .push_data (pixel_push_data), .full (pixel_full),
    .pop  (pixel_pop),  .pop_data  (pixel_pop_data),  .empty (pixel_empty),
    .level (pixel_level)
  );

  //////////////////////////////////////////////////
  // Add and send
  //////////////////////////////////////////////////

  bias_add bias_add_i (
    .clk, .reset,
    .src_empty (pixel_empty), .src_data (pixel_pop_data), .src_pop (pixel_pop),
    .dst_level (result_level),
    .dst_push  (result_push), .dst_data (result_push_data)
  );

  // Full never seen here, issue is credit checked upstream
  stream_fifo #(
    .payload_t (bias_pkg::acc_t),
    .DEPTH     (bias_pkg::OUT_FIFO_DEPTH)
  ) result_fifo (
    .clk, .reset,
    .push (result_push), .push_data (result_push_data), .full (),
    .pop  (result_pop),  .pop_data  (result_pop_data),  .empty (result_empty),
    .level (result_level)
  );

  result_sender result_sender_i (
    .clk, .reset,
    .fifo_empty (result_empty), .fifo_data (result_pop_data), .fifo_pop (result_pop),
    .out_ack, .out_req, .out_data
  );

endmodule

// ==== verilog/pixel_receiver.sv ====
`timescale 1ns/100ps

module pixel_receiver (
  input  logic                              clk,
  input  logic                              reset,
  // Four-phase input link
  input  logic                              in_req,
  input  logic [bias_pkg::PIXEL_W-1:0]      in_pixel,
  input  logic [bias_pkg::CHAN_W-1:0]       in_channel,
  output logic                              in_ack,
  // Bias table write port
  input  logic                              bias_wr_en,
  input  logic [bias_pkg::CHAN_W-1:0]       bias_wr_channel,
  input  logic [bias_pkg::BIAS_W-1:0]       bias_wr_data,
  // Pixel FIFO push side
  input  logic                              fifo_full,
  output logic                              fifo_push,
  output bias_pkg::pixel_entry_t            fifo_push_data
);

  typedef enum logic [1:0] {
    st_idle,     // Waiting for in_req
    st_push,     // Request seen, push once FIFO has room
    st_ack,      // Entry pushed, ack raised
    st_release   // Holding ack until the source lets go
  } rx_state_t;

  rx_state_t state;

  // One bias word per channel
  logic [bias_pkg::BIAS_W-1:0] bias_table [bias_pkg::NUM_CHANNELS];

  //////////////////////////////////////////////////
  // Bias table
  //////////////////////////////////////////////////

  // Written at the edge, so a lookup one cycle later sees it
  always_ff @(posedge clk) begin
    if (bias_wr_en) begin
      bias_table[bias_wr_channel] <= bias_wr_data;
    end
  end

  //////////////////////////////////////////////////
  // Four-phase handshake
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (in_req) state <= st_push;
        end
        st_push: begin
          if (!fifo_full) state <= st_ack;  // Push happens this cycle
        end
        st_ack: begin
          // Source may already have dropped req
          state <= in_req ? st_release : st_idle;
        end
        st_release: begin
          if (!in_req) state <= st_idle;  // Ack falls next cycle
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Exactly one push per request, only with room
  assign fifo_push = (state == st_push) && !fifo_full;

  // Data is stable while in_req is high, so read it straight off the link
  assign fifo_push_data.pixel = in_pixel;
  assign fifo_push_data.bias  = bias_table[in_channel];  // Lookup by channel

  // High from the cycle after the push until req is seen low
  assign in_ack = (state == st_ack) || (state == st_release);

endmodule

// ==== verilog/result_sender.sv ====
`timescale 1ns/100ps

module result_sender (
  input  logic                       clk,
  input  logic                       reset,
  // Result FIFO read side
  input  logic                       fifo_empty,
  input  bias_pkg::acc_t             fifo_data,
  output logic                       fifo_pop,
  // Four-phase output link
  input  logic                       out_ack,
  output logic                       out_req,
  output logic [bias_pkg::ACC_W-1:0] out_data
);

  typedef enum logic [1:0] {
    st_idle,     // Free to take the next result
    st_req,      // Req high, waiting for ack
    st_release   // Req dropped, waiting for ack low
  } tx_state_t;

  tx_state_t state;

  //////////////////////////////////////////////////
  // Handshake FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (!fifo_empty) state <= st_req;  // Pop this cycle
        end
        st_req: begin
          if (out_ack) state <= st_release;
        end
        st_release: begin
          // Cycle closes only once the sink drops ack
          if (!out_ack) state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  assign fifo_pop = (state == st_idle) && !fifo_empty;

  // Held for the whole req/ack cycle
  always_ff @(posedge clk) begin
    if (fifo_pop) begin
      out_data <= fifo_data;
    end
  end

  assign out_req = (state == st_req);  // Rises the cycle after the pop

endmodule

// ==== verilog/stream_fifo.sv ====
`timescale 1ns/100ps

module stream_fifo #(
  parameter type payload_t = logic [7:0],  // Entry type
  parameter int  DEPTH     = 4             // Power of two
) (
  input  logic                         clk,
  input  logic                         reset,
  // Write side
  input  logic                         push,
  input  payload_t                     push_data,
  output logic                         full,
  // Read side, head shown while not empty
  input  logic                         pop,
  output payload_t                     pop_data,
  output logic                         empty,
  output logic [bias_pkg::LEVEL_W-1:0] level
);

  payload_t mem [DEPTH];  // Storage, no reset

  logic [$clog2(DEPTH)-1:0] wr_ptr;
  logic [$clog2(DEPTH)-1:0] rd_ptr;
  logic [bias_pkg::LEVEL_W-1:0] count;  // Entries held, 0..DEPTH

  logic do_push;
  logic do_pop;

  // Requests against a full or empty buffer are dropped
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  assign pop_data = mem[rd_ptr];  // Head entry

  //////////////////////////////////////////////////
  // Pointers and count
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;  // Wraps at DEPTH
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

  assign full  = (int'(count) == DEPTH);
  assign empty = (count == '0);
  assign level = count;

endmodule
